//--- src.f
source/mipsPkg.sv
source/instDecode.sv
source/regFile.sv
source/aluExecute.sv
source/pcNext.sv
source/writeBack.sv
source/mipsCore.sv
verification/mipsTb.sv

//--- Makefile
# Verilator build and run for the single-cycle MIPS core

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mipsTb
FILELIST  = src.f
OBJDIR    = obj_dir
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- verification/mipsTb.sv
/*
  Testbench for the single-cycle MIPS core
  instruction and data memory models, directed tests
  for fetch, ALU, r0, beq, j/jal/jr and lw/sw addressing
*/
`timescale 1ns/100ps

module mipsTb;

  localparam int             DataAddrWidth = 7;
  localparam mipsPkg::word_t ResetPc       = 32'h0000_0040;
  localparam int             ClkPeriod     = 100;
  localparam int             ImemBits      = 7;
  localparam int             Seed          = 32'h9c86_4be5;
  // run cycles of all tests plus about 4 reset cycles each
  localparam int             TotalCycles   = (3 + 14 + 3 + 4 + 4 + 2) + 6 * 4;

  logic                     clk;
  logic                     rst;
  mipsPkg::instWord_t       inst;
  mipsPkg::word_t           memReadData;
  mipsPkg::word_t           instAddr;
  logic                     memCen;
  logic                     memWen;
  logic [DataAddrWidth-1:0] memAddr;
  mipsPkg::word_t           memWriteData;
  mipsPkg::word_t           rfWriteData;

  mipsPkg::word_t imem [0:(1 << ImemBits) - 1];
  mipsPkg::word_t dmem [0:(1 << DataAddrWidth) - 1];
  int             errCount;

  mipsCore #(.DataAddrWidth(DataAddrWidth), .ResetPc(ResetPc)) dut_i (
    .clk(clk), .rst(rst), .inst(inst), .memReadData(memReadData),
    .instAddr(instAddr), .memCen(memCen), .memWen(memWen), .memAddr(memAddr),
    .memWriteData(memWriteData), .rfWriteData(rfWriteData)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // ==============================
  // memory models
  // ==============================
  // combinational fetch by word index of the byte address
  assign inst        = imem[instAddr[ImemBits+1:2]];
  assign memReadData = dmem[memAddr];

  // SRAM write on the edge while both strobes are low
  always @(posedge clk) begin
    if (!memCen && !memWen) begin
      dmem[memAddr] <= memWriteData;
    end
  end

  function automatic mipsPkg::word_t progAddr(input int k);
    return ResetPc + 32'(4 * k);
  endfunction

  function automatic mipsPkg::word_t fillWord(input int i);
    return 32'h5a5a_0000 + 32'(i * 3);
  endfunction

  function automatic mipsPkg::word_t dataAt(input int i);
    return dmem[DataAddrWidth'(i)];
  endfunction

  task automatic setData(input int i, input mipsPkg::word_t w);
    dmem[DataAddrWidth'(i)] = w;
  endtask

  // k-th instruction slot counted from ResetPc
  task automatic placeInst(input int k, input mipsPkg::word_t w);
    mipsPkg::word_t a;
    a = progAddr(k);
    imem[a[ImemBits+1:2]] = w;
  endtask

  // nops everywhere and data words tagged by index
  task automatic clearMemories();
    for (int i = 0; i < (1 << ImemBits); i++) begin
      imem[ImemBits'(i)] = '0;
    end
    for (int i = 0; i < (1 << DataAddrWidth); i++) begin
      setData(i, fillWord(i));
    end
  endtask

  // ==============================
  // instruction encoding
  // ==============================
  function automatic mipsPkg::word_t rTypeWord(input logic [5:0] funct,
      input mipsPkg::regAddr_t rs, input mipsPkg::regAddr_t rt, input mipsPkg::regAddr_t rd);
    return {mipsPkg::opRType, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic mipsPkg::word_t iTypeWord(input logic [5:0] op,
      input mipsPkg::regAddr_t rs, input mipsPkg::regAddr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic mipsPkg::word_t jumpWord(input logic [5:0] op, input mipsPkg::word_t addr);
    return {op, addr[27:2]};
  endfunction

  // ==============================
  // reset and stepping
  // ==============================
  // returns mid-cycle with rst already low
  task automatic holdReset();
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
  endtask

  task automatic releaseReset();
    repeat (2) @(posedge clk);
    rst <= 1'b1;
  endtask

  // n instructions complete before the falling-edge sample
  task automatic runCycles(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic checkWord(input string name, input mipsPkg::word_t got,
      input mipsPkg::word_t exp);
    if (got !== exp) begin
      errCount++;
      $display("ERR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkAddr(input string name, input logic [DataAddrWidth-1:0] got,
      input logic [DataAddrWidth-1:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("ERR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic resetAndFetch();
    holdReset();
    clearMemories();
    checkWord("instAddr", instAddr, ResetPc);
    checkWord("memWen", {31'd0, memWen}, 32'd1);
    checkWord("memCen", {31'd0, memCen}, 32'd1);
    releaseReset();
    for (int k = 1; k <= 3; k++) begin
      runCycles(1);
      checkWord("instAddr", instAddr, progAddr(k));
    end
  endtask

  task automatic aluArithmetic();
    mipsPkg::word_t a;
    mipsPkg::word_t b;
    holdReset();
    clearMemories();
    // a negative and b positive, so signed slt differs from unsigned
    a = $urandom | 32'h8000_0000;
    b = $urandom & 32'h7fff_ffff;
    setData(0, a);
    setData(1, b);
    placeInst(0, iTypeWord(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
    placeInst(1, iTypeWord(mipsPkg::opLw, 5'd0, 5'd2, 16'd4));
    placeInst(2, rTypeWord(mipsPkg::fnAdd, 5'd1, 5'd2, 5'd3));
    placeInst(3, rTypeWord(mipsPkg::fnSub, 5'd1, 5'd2, 5'd4));
    placeInst(4, rTypeWord(mipsPkg::fnAnd, 5'd1, 5'd2, 5'd5));
    placeInst(5, rTypeWord(mipsPkg::fnOr, 5'd1, 5'd2, 5'd6));
    placeInst(6, rTypeWord(mipsPkg::fnSlt, 5'd1, 5'd2, 5'd7));
    placeInst(7, rTypeWord(mipsPkg::fnSlt, 5'd2, 5'd1, 5'd8));
    // r3..r8 to words 2..7
    for (int r = 3; r <= 8; r++) begin
      placeInst(r + 5, iTypeWord(mipsPkg::opSw, 5'd0, 5'(r), 16'(4 * (r - 1))));
    end
    releaseReset();
    runCycles(14);
    checkWord("dmem[2] add", dataAt(2), a + b);
    checkWord("dmem[3] sub", dataAt(3), a - b);
    checkWord("dmem[4] and", dataAt(4), a & b);
    checkWord("dmem[5] or", dataAt(5), a | b);
    checkWord("dmem[6] slt", dataAt(6), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    checkWord("dmem[7] slt", dataAt(7), ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
  endtask

  task automatic zeroRegister();
    holdReset();
    clearMemories();
    setData(0, $urandom | 32'd1);
    placeInst(0, iTypeWord(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
    placeInst(1, rTypeWord(mipsPkg::fnAdd, 5'd1, 5'd1, 5'd0));
    placeInst(2, iTypeWord(mipsPkg::opSw, 5'd0, 5'd0, 16'd8));
    releaseReset();
    runCycles(3);
    checkWord("dmem[2] r0", dataAt(2), 32'd0);
  endtask

  task automatic branchFlow();
    mipsPkg::word_t v;
    holdReset();
    clearMemories();
    v = $urandom | 32'd1;
    setData(0, v);
    setData(1, v);
    placeInst(0, iTypeWord(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
    placeInst(1, iTypeWord(mipsPkg::opLw, 5'd0, 5'd2, 16'd4));
    placeInst(2, iTypeWord(mipsPkg::opBeq, 5'd1, 5'd2, 16'd2));
    // marker on the skipped path
    placeInst(3, iTypeWord(mipsPkg::opSw, 5'd0, 5'd1, 16'd8));
    placeInst(4, iTypeWord(mipsPkg::opSw, 5'd0, 5'd1, 16'd8));
    // r1 is nonzero, so this one falls through
    placeInst(5, iTypeWord(mipsPkg::opBeq, 5'd1, 5'd0, 16'd3));
    releaseReset();
    runCycles(2);
    runCycles(1);
    checkWord("instAddr taken", instAddr, progAddr(2) + 32'd4 + 32'd8);
    runCycles(1);
    checkWord("instAddr not taken", instAddr, progAddr(5) + 32'd4);
    checkWord("dmem[2] marker", dataAt(2), fillWord(2));
  endtask

  task automatic jumpAndLink();
    holdReset();
    clearMemories();
    placeInst(0, jumpWord(mipsPkg::opJal, progAddr(5)));
    placeInst(1, iTypeWord(mipsPkg::opSw, 5'd0, 5'd31, 16'd8));
    placeInst(2, jumpWord(mipsPkg::opJ, progAddr(8)));
    placeInst(5, rTypeWord(mipsPkg::fnJr, 5'd31, 5'd0, 5'd0));
    releaseReset();
    // still inside the jal cycle
    runCycles(0);
    checkWord("rfWriteData", rfWriteData, progAddr(0) + 32'd4);
    runCycles(1);
    checkWord("instAddr jal", instAddr, progAddr(5));
    runCycles(1);
    checkWord("instAddr jr", instAddr, progAddr(1));
    runCycles(2);
    checkWord("instAddr j", instAddr, progAddr(8));
    checkWord("dmem[2] link", dataAt(2), progAddr(1));
  endtask

  task automatic loadStoreAddressing();
    mipsPkg::word_t           base;
    logic [15:0]              off;
    logic [DataAddrWidth-1:0] expIdx;
    holdReset();
    clearMemories();
    // byte 0x280 is word 0xa0 and wraps to index 0x20
    base = 32'h0000_0284;
    off  = 16'hfffc;
    expIdx = DataAddrWidth'((base - 32'd4) / 32'd4);
    setData(0, base);
    placeInst(0, iTypeWord(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
    placeInst(1, iTypeWord(mipsPkg::opSw, 5'd1, 5'd1, off));
    releaseReset();
    runCycles(1);
    checkAddr("memAddr", memAddr, expIdx);
    checkWord("memWen", {31'd0, memWen}, 32'd0);
    checkWord("memCen", {31'd0, memCen}, 32'd0);
    runCycles(1);
    checkWord("dmem[idx]", dataAt(int'(expIdx)), base);
  endtask

  // ==============================
  // sequence and watchdog
  // ==============================
  initial begin
    errCount = 0;
    rst = 1'b0;
    void'($urandom(Seed));
    clearMemories();
    resetAndFetch();
    aluArithmetic();
    zeroRegister();
    branchFlow();
    jumpAndLink();
    loadStoreAddressing();
    $display("tests complete, %0d errors", errCount);
    if (errCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(TotalCycles * ClkPeriod * 2);
    $display("timeout: the tests did not complete in the expected time");
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- source/mipsCore.sv
/*
  Single-cycle MIPS core
  one instruction per clock, combinational instruction port,
  SRAM-style data port with active-low enables
*/
`timescale 1ns/100ps

module mipsCore #(
  parameter int             DataAddrWidth = 7,
  parameter mipsPkg::word_t ResetPc       = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  mipsPkg::instWord_t       inst,
  input  mipsPkg::word_t           memReadData,
  output mipsPkg::word_t           instAddr,
  output logic                     memCen,
  output logic                     memWen,
  output logic [DataAddrWidth-1:0] memAddr,
  output mipsPkg::word_t           memWriteData,
  output mipsPkg::word_t           rfWriteData
);

  // decode controls
  logic            regDst;
  logic            aluSrc;
  logic            memToReg;
  logic            regWrite;
  logic            memRead;
  logic            memWrite;
  logic            jump;
  logic            branch;
  logic            jr;
  logic            isJal;
  mipsPkg::aluOp_t aluOp;

  // datapath
  mipsPkg::word_t    rsData;
  mipsPkg::word_t    rtData;
  mipsPkg::word_t    aluResult;
  logic              aluZero;
  mipsPkg::word_t    pc;
  mipsPkg::word_t    pcPlus4;
  mipsPkg::regAddr_t wrAddr;
  mipsPkg::word_t    wrData;

  // ==============================
  // decode
  // ==============================
  instDecode decodeInst (
    .inst(inst), .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
    .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
    .jump(jump), .branch(branch), .jr(jr), .isJal(isJal), .aluOp(aluOp)
  );

  // rs/rt fields sit at the same place in R and I formats
  regFile regsInst (
    .clk(clk), .rst(rst), .regWrite(regWrite),
    .rsAddr(inst.rFmt.rs), .rtAddr(inst.rFmt.rt),
    .wrAddr(wrAddr), .wrData(wrData), .rsData(rsData), .rtData(rtData)
  );

  // ==============================
  // execute and next pc
  // ==============================
  aluExecute aluInst (
    .rsData(rsData), .rtData(rtData), .imm(inst.iFmt.imm), .aluSrc(aluSrc),
    .aluOp(aluOp), .aluResult(aluResult), .aluZero(aluZero)
  );

  pcNext #(.ResetPc(ResetPc)) pcInst (
    .clk(clk), .rst(rst), .jump(jump), .branch(branch), .jr(jr),
    .aluZero(aluZero), .rsData(rsData), .imm(inst.iFmt.imm),
    .target(inst.jFmt.target), .pc(pc), .pcPlus4(pcPlus4)
  );

  // ==============================
  // result and memory
  // ==============================
  writeBack #(.DataAddrWidth(DataAddrWidth)) wbInst (
    .rst(rst), .regDst(regDst), .memToReg(memToReg), .isJal(isJal),
    .memRead(memRead), .memWrite(memWrite),
    .rtAddr(inst.rFmt.rt), .rdAddr(inst.rFmt.rd),
    .aluResult(aluResult), .memReadData(memReadData), .pcPlus4(pcPlus4),
    .rtData(rtData), .wrAddr(wrAddr), .wrData(wrData),
    .memCen(memCen), .memWen(memWen), .memAddr(memAddr),
    .memWriteData(memWriteData)
  );

  // fetch address is the pc itself
  assign instAddr = pc;

  // observation tap of the register write value
  assign rfWriteData = wrData;

endmodule

//--- source/writeBack.sv
/*
  Result select and data memory port
  destination register and write-back value,
  active-low SRAM controls and word address
*/
`timescale 1ns/100ps

module writeBack #(
  parameter int DataAddrWidth = 7
) (
  input  logic                     rst,
  input  logic                     regDst,
  input  logic                     memToReg,
  input  logic                     isJal,
  input  logic                     memRead,
  input  logic                     memWrite,
  input  mipsPkg::regAddr_t        rtAddr,
  input  mipsPkg::regAddr_t        rdAddr,
  input  mipsPkg::word_t           aluResult,
  input  mipsPkg::word_t           memReadData,
  input  mipsPkg::word_t           pcPlus4,
  input  mipsPkg::word_t           rtData,
  output mipsPkg::regAddr_t        wrAddr,
  output mipsPkg::word_t           wrData,
  output logic                     memCen,
  output logic                     memWen,
  output logic [DataAddrWidth-1:0] memAddr,
  output mipsPkg::word_t           memWriteData
);

  // ==============================
  // register write-back
  // ==============================
  // jal links to r31, R-type writes rd, loads write rt
  assign wrAddr = isJal ? 5'd31 : (regDst ? rdAddr : rtAddr);
  assign wrData = isJal ? pcPlus4 : (memToReg ? memReadData : aluResult);

  // ==============================
  // data memory
  // ==============================
  // both strobes parked high while in reset
  assign memCen = !(rst && (memRead || memWrite));
  assign memWen = !(rst && memWrite);

  // byte address -> word index, low two bits dropped
  assign memAddr      = aluResult[DataAddrWidth+1:2];
  assign memWriteData = rtData;

  // a write strobe without chip enable would be lost by the SRAM
  always_comb begin
    assert (memWen || !memCen) else $error("writeBack: memWen low with memCen high");
  end

endmodule

//--- source/pcNext.sv
/*
  Program counter
  PC register with next-address selection
  for sequential flow, beq, j/jal and jr
*/
`timescale 1ns/100ps

module pcNext #(
  parameter mipsPkg::word_t ResetPc = '0
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           jump,
  input  logic           branch,
  input  logic           jr,
  input  logic           aluZero,
  input  mipsPkg::word_t rsData,
  input  logic [15:0]    imm,
  input  logic [25:0]    target,
  output mipsPkg::word_t pc,
  output mipsPkg::word_t pcPlus4
);

  mipsPkg::word_t pcReg;
  mipsPkg::word_t jumpAddr;
  mipsPkg::word_t branchAddr;
  mipsPkg::word_t pcNextVal;

  assign pcPlus4 = pcReg + 32'd4;

  // region bits come from the next instruction address
  assign jumpAddr = {pcPlus4[31:28], target, 2'b00};

  // word offset, sign-extended and scaled to bytes
  assign branchAddr = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};

  // ==============================
  // next pc, jump wins over branch over jr
  // ==============================
  always_comb begin
    if (jump) begin
      pcNextVal = jumpAddr;
    end else if (branch && aluZero) begin
      pcNextVal = branchAddr;
    end else if (jr) begin
      pcNextVal = rsData;
    end else begin
      pcNextVal = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= ResetPc;
    end else begin
      pcReg <= pcNextVal;
    end
  end

  assign pc = pcReg;

  // jr target and reset value must keep fetches on word boundaries
  pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00);

endmodule

//--- source/aluExecute.sv
/*
  Execute stage
  immediate sign extension, second operand select,
  add/sub/and/or/signed slt and the zero flag
*/
`timescale 1ns/100ps

module aluExecute (
  input  mipsPkg::word_t  rsData,
  input  mipsPkg::word_t  rtData,
  input  logic [15:0]     imm,
  input  logic            aluSrc,
  input  mipsPkg::aluOp_t aluOp,
  output mipsPkg::word_t  aluResult,
  output logic            aluZero
);

  mipsPkg::word_t immExt;
  mipsPkg::word_t opB;
  logic           lessThan;

  // ==============================
  // operands
  // ==============================
  // 16-bit offset widened with its sign
  assign immExt = {{16{imm[15]}}, imm};

  // lw/sw use the offset, the rest use rt
  assign opB = aluSrc ? immExt : rtData;

  // slt compares as two's complement
  assign lessThan = $signed(rsData) < $signed(opB);

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    case (aluOp)
      mipsPkg::aluAdd: aluResult = rsData + opB;
      mipsPkg::aluSub: aluResult = rsData - opB;
      mipsPkg::aluAnd: aluResult = rsData & opB;
      mipsPkg::aluOr:  aluResult = rsData | opB;
      mipsPkg::aluSlt: aluResult = {31'd0, lessThan};
      default:         aluResult = '0;
    endcase
  end

  // raw zero test of the result
  // only beq looks at it, via pcNext
  assign aluZero = (aluResult == '0);

endmodule

//--- source/regFile.sv
/*
  Register file
  31 general registers, r0 hard-wired to zero,
  two combinational read ports and one write port
*/
`timescale 1ns/100ps

module regFile (
  input  logic              clk,
  input  logic              rst,
  input  logic              regWrite,
  input  mipsPkg::regAddr_t rsAddr,
  input  mipsPkg::regAddr_t rtAddr,
  input  mipsPkg::regAddr_t wrAddr,
  input  mipsPkg::word_t    wrData,
  output mipsPkg::word_t    rsData,
  output mipsPkg::word_t    rtData
);

  // no storage behind r0
  mipsPkg::word_t regs [1:31];

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (wrAddr != 5'd0)) begin
      // writes to r0 just fall away
      regs[wrAddr] <= wrData;
    end
  end

  // ==============================
  // read ports
  // ==============================
  // new value visible only after the edge, no bypass
  assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];

  // r0 reads stay zero whatever was written to it earlier
  rsZero: assert property (@(posedge clk) disable iff (!rst)
    (rsAddr == 5'd0) |-> (rsData == '0));
  rtZero: assert property (@(posedge clk) disable iff (!rst)
    (rtAddr == 5'd0) |-> (rtData == '0));

endmodule

//--- source/instDecode.sv
/*
  Instruction decode
  opcode and function field to datapath controls
  and ALU operation in a single combinational step
*/
`timescale 1ns/100ps

module instDecode (
  input  mipsPkg::instWord_t inst,
  output logic               regDst,
  output logic               aluSrc,
  output logic               memToReg,
  output logic               regWrite,
  output logic               memRead,
  output logic               memWrite,
  output logic               jump,
  output logic               branch,
  output logic               jr,
  output logic               isJal,
  output mipsPkg::aluOp_t    aluOp
);

  always_comb begin
    // defaults give no writes and sequential flow
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    jump     = 1'b0;
    branch   = 1'b0;
    jr       = 1'b0;
    isJal    = 1'b0;
    aluOp    = mipsPkg::aluAdd;

    case (inst.rFmt.op)
      mipsPkg::opRType: begin
        // rd destination unless funct turns out unusable
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (inst.rFmt.funct)
          mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
          mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
          mipsPkg::fnJr: begin
            // jr only redirects, nothing written back
            regDst   = 1'b0;
            regWrite = 1'b0;
            jr       = 1'b1;
          end
          default: begin
            regDst   = 1'b0;
            regWrite = 1'b0;
          end
        endcase
      end
      mipsPkg::opLw: begin
        // address = rs + sext(imm)
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      mipsPkg::opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsPkg::opBeq: begin
        // equal when rs - rt is zero
        branch = 1'b1;
        aluOp  = mipsPkg::aluSub;
      end
      mipsPkg::opJ: begin
        jump = 1'b1;
      end
      mipsPkg::opJal: begin
        // link to r31, address picked in write-back
        jump     = 1'b1;
        isJal    = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

  // pc selection in pcNext relies on one redirect source at a time
  always_comb begin
    assert ($onehot0({jump, branch, jr}))
      else $error("instDecode: more than one redirect for op %h", inst.rFmt.op);
  end

endmodule

//--- source/mipsPkg.sv
/*
  MIPS core shared definitions
  opcode and function encodings, ALU operation codes
  and the instruction word with its R, I and J views
*/
package mipsPkg;

  // ==============================
  // basic words
  // ==============================
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;

  // ==============================
  // opcodes, bits 31..26
  // ==============================
  localparam logic [5:0] opRType = 6'b000000;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;

  // R-type function field, bits 5..0
  localparam logic [5:0] fnJr  = 6'b001000;
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // internal ALU operation select
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOp_t;

  // ==============================
  // instruction word, three formats
  // ==============================
  typedef union packed {
    struct packed {
      logic [5:0] op;
      regAddr_t   rs;
      regAddr_t   rt;
      regAddr_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } rFmt;
    struct packed {
      logic [5:0]  op;
      regAddr_t    rs;
      regAddr_t    rt;
      logic [15:0] imm;
    } iFmt;
    struct packed {
      logic [5:0]  op;
      logic [25:0] target;
    } jFmt;
  } instWord_t;

endpackage
